// ==== tb.f ====
logic/cal_pkg.sv
logic/key_decode.sv
logic/cal_ctrl.sv
logic/cal_execute.sv
logic/bin2bcd.sv
logic/seg_display.sv
logic/cal_top.sv
test/cal_props.sv
test/cal_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the calculator testbench, pass only if the log holds the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module cal_tb \
    -o cal_sim > build.log 2>&1 &&
./obj_dir/cal_sim > sim.log 2>&1 ||
{ echo "build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -q "^TEST OK$" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

// ==== test/cal_tb.sv ====
// calculator testbench with clock, reset, button stimulus, reference model, checks and timeout
`timescale 1ns/1ps
`default_nettype none

module cal_tb
    import cal_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 40000;
    localparam int HOLD_CYCLES    = 6;

    logic                clk;
    logic                rst_n;
    logic [BUTTON_W-1:0] board_cal_button;
    logic [SWITCH_W-1:0] board_cal_switchs;
    logic [3:0]          cal_board_digit_ctrl;
    logic [7:0]          cal_board_digit_seg;
    logic                cal_board_exe_done;
    logic [2:0]          cal_board_display_stage;
    int                  errors = 0;
    int                  checks = 0;
    int                  cycles = 0;

    cal_top cal_top_i (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .board_cal_button        (board_cal_button),
        .board_cal_switchs       (board_cal_switchs),
        .cal_board_digit_ctrl    (cal_board_digit_ctrl),
        .cal_board_digit_seg     (cal_board_digit_seg),
        .cal_board_exe_done      (cal_board_exe_done),
        .cal_board_display_stage (cal_board_display_stage)
    );

    bind cal_ctrl cal_props cal_props_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .exe_req (exe_req),
        .exe_ack (exe_ack),
        .cvt_req (cvt_req),
        .cvt_ack (cvt_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // active-low board segment table
    function automatic logic [7:0] seg_of(logic [3:0] code);
        case (code)
            4'h0:    return 8'h03;
            4'h1:    return 8'h9f;
            4'h2:    return 8'h25;
            4'h3:    return 8'h0d;
            4'h4:    return 8'h99;
            4'h5:    return 8'h49;
            4'h6:    return 8'h41;
            4'h7:    return 8'h1f;
            4'h8:    return 8'h01;
            4'h9:    return 8'h19;
            4'hb:    return 8'hfd;
            default: return 8'hff;
        endcase
    endfunction

    function automatic logic [31:0] codes_to_segs(logic [15:0] codes);
        logic [31:0] segs;
        int          p;
        for (p = 0; p < 4; p++) begin
            segs[p*8 +: 8] = seg_of(codes[p*4 +: 4]);
        end
        return segs;
    endfunction

    function automatic logic [31:0] entry_segs(int hundreds, int tens, int ones, bit neg);
        logic [15:0] codes;
        codes[3:0]   = 4'(ones);
        codes[7:4]   = 4'(tens);
        codes[11:8]  = 4'(hundreds);
        codes[15:12] = neg ? CODE_MINUS : CODE_BLANK;
        return codes_to_segs(codes);
    endfunction

    function automatic bit invalid_op(logic [SWITCH_W-1:0] sw);
        return sw[2:0] == 3'b000;
    endfunction

    // lowest set switch picks the operation
    function automatic int expected_value(int a, int b, logic [SWITCH_W-1:0] sw);
        if (sw[OP_ADD]) begin
            return a + b;
        end
        if (sw[OP_SUB]) begin
            return a - b;
        end
        if (sw[OP_MUL]) begin
            return a * b;
        end
        return 0;
    endfunction

    function automatic int result_pages(int value);
        return ((value < 0 ? -value : value) >= 1000) ? 2 : 1;
    endfunction

    function automatic logic [31:0] result_segs(int value, int page);
        logic [15:0] codes;
        int          dig[6];
        int          mag;
        int          base;
        int          i;
        mag = value < 0 ? -value : value;
        for (i = 0; i < 6; i++) begin
            dig[i] = mag % 10;
            mag    = mag / 10;
        end
        base = (result_pages(value) == 2 && page == 0) ? 3 : 0;
        for (i = 0; i < 3; i++) begin
            codes[i*4 +: 4] = 4'(dig[base+i]);
        end
        codes[15:12] = value < 0 ? CODE_MINUS : CODE_BLANK;
        return codes_to_segs(codes);
    endfunction

    function automatic int random_operand();
        int mag;
        mag = int'($urandom % 1000);
        if ($urandom % 2 == 1) begin
            return -mag;
        end
        return mag;
    endfunction

    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic press(int idx);
        @(posedge clk);
        board_cal_button[idx] <= 1'b1;
        repeat (HOLD_CYCLES) @(posedge clk);
        board_cal_button[idx] <= 1'b0;
        repeat (HOLD_CYCLES - 1) @(posedge clk);
    endtask

    // collect segments per lit position over one full scan
    task automatic read_display(output logic [31:0] segs, output logic dark);
        logic [3:0] sel;
        int         p;
        segs = '1;
        dark = 1'b1;
        repeat (4 * SCAN_TICKS) begin
            @(negedge clk);
            for (p = 0; p < 4; p++) begin
                sel = 4'b0001 << p;
                if (cal_board_digit_ctrl == ~sel) begin
                    segs[p*8 +: 8] = cal_board_digit_seg;
                    dark           = 1'b0;
                end
            end
        end
    endtask

    task automatic set_digit(int d);
        if (d <= 5) begin
            repeat (d) press(BTN_UP);
        end else begin
            repeat (10 - d) press(BTN_DOWN);
        end
    endtask

    // cursor starts on digit 0
    task automatic enter_operand(int value, string name);
        logic [31:0] segs;
        logic        dark;
        int          mag;
        mag = value < 0 ? -value : value;
        set_digit(mag % 10);
        press(BTN_LEFT);
        set_digit((mag / 10) % 10);
        press(BTN_LEFT);
        set_digit(mag / 100);
        press(BTN_LEFT);
        if (value < 0) begin
            press(BTN_UP);
        end
        read_display(segs, dark);
        compare_value(name, entry_segs(mag / 100, (mag / 10) % 10, mag % 10, value < 0), segs);
    endtask

    task automatic check_entry();
        logic [31:0] segs;
        logic        dark;
        press(BTN_DOWN);
        read_display(segs, dark);
        compare_value("entry wrap down", entry_segs(0, 0, 9, 0), segs);
        press(BTN_UP);
        read_display(segs, dark);
        compare_value("entry wrap up", entry_segs(0, 0, 0, 0), segs);
        press(BTN_LEFT);
        press(BTN_UP);
        press(BTN_LEFT);
        press(BTN_DOWN);
        press(BTN_LEFT);
        press(BTN_UP);
        read_display(segs, dark);
        compare_value("entry cursor left", entry_segs(9, 1, 0, 1), segs);
        // left on the sign stays put and down toggles it back
        press(BTN_LEFT);
        press(BTN_DOWN);
        read_display(segs, dark);
        compare_value("entry sign toggle", entry_segs(9, 1, 0, 0), segs);
        press(BTN_RIGHT);
        press(BTN_UP);
        press(BTN_RIGHT);
        press(BTN_DOWN);
        press(BTN_RIGHT);
        press(BTN_RIGHT);
        press(BTN_UP);
        read_display(segs, dark);
        compare_value("entry cursor right", entry_segs(0, 0, 1, 0), segs);
        press(BTN_DOWN);
    endtask

    task automatic run_op(string name, int a, int b, logic [SWITCH_W-1:0] sw);
        logic [31:0] segs;
        logic        dark;
        int          value;
        int          pg;
        @(posedge clk);
        board_cal_switchs <= sw;
        enter_operand(a, $sformatf("%s operand a", name));
        press(BTN_MID);
        enter_operand(b, $sformatf("%s operand b", name));
        press(BTN_MID);
        while (cal_board_exe_done !== 1'b1) begin
            @(posedge clk);
        end
        value = expected_value(a, b, sw);
        if (invalid_op(sw)) begin
            read_display(segs, dark);
            compare_value($sformatf("%s dark", name), 32'd1, dark);
            compare_value($sformatf("%s digit_ctrl", name), 32'hf, cal_board_digit_ctrl);
            press(BTN_MID);
        end else begin
            for (pg = 0; pg < result_pages(value); pg++) begin
                @(negedge clk);
                compare_value($sformatf("%s stage", name), pg + 1, cal_board_display_stage);
                read_display(segs, dark);
                compare_value($sformatf("%s page %0d", name, pg + 1),
                              result_segs(value, pg), segs);
                press(BTN_MID);
            end
        end
        @(negedge clk);
        compare_value($sformatf("%s exe_done", name), 32'd0, cal_board_exe_done);
        compare_value($sformatf("%s stage after", name), 32'd0, cal_board_display_stage);
        read_display(segs, dark);
        compare_value($sformatf("%s entry cleared", name), entry_segs(0, 0, 0, 0), segs);
    endtask

    initial begin
        logic [31:0] segs;
        logic        dark;
        int          i;
        rst_n             = 1'b0;
        board_cal_button  = '0;
        board_cal_switchs = '0;
        void'($urandom(32'hc24bb28d));
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_value("reset exe_done", 32'd0, cal_board_exe_done);
        compare_value("reset stage", 32'd0, cal_board_display_stage);
        read_display(segs, dark);
        compare_value("reset entry", entry_segs(0, 0, 0, 0), segs);

        check_entry();

        for (i = 0; i < 8; i++) begin
            if (i % 2 == 1) begin
                run_op($sformatf("sub %0d", i), random_operand(), random_operand(),
                       15'(1 << OP_SUB));
            end else begin
                run_op($sformatf("add %0d", i), random_operand(), random_operand(),
                       15'(1 << OP_ADD));
            end
        end

        run_op("mul two pages", 123, -456, 15'(1 << OP_MUL));
        run_op("mul largest", 999, 999, 15'(1 << OP_MUL));
        run_op("mul one page", -12, -34, 15'(1 << OP_MUL));

        // lowest of several set switches wins
        run_op("priority sub", 250, -75, 15'h0006);
        run_op("priority add", -300, 41, 15'h7fff);
        run_op("priority mul", 17, 85, 15'h7ffc);

        run_op("invalid none", 5, 6, 15'h0000);
        run_op("invalid switch 3", 7, 8, 15'h0008);
        run_op("invalid switch 14", 1, 2, 15'h4000);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/cal_props.sv ====
// req/ack handshake assertions for the controller exe and cvt ports
`timescale 1ns/1ps
`default_nettype none

module cal_props (
    input logic clk,
    input logic rst_n,
    input logic exe_req,
    input logic exe_ack,
    input logic cvt_req,
    input logic cvt_ack
);

    // req held until ack
    exe_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        exe_req && !exe_ack |=> exe_req)
        else $error("exe_req dropped before exe_ack");
    cvt_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cvt_req && !cvt_ack |=> cvt_req)
        else $error("cvt_req dropped before cvt_ack");

    // ack only answers a pending req
    exe_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(exe_ack) |-> exe_req)
        else $error("exe_ack rose without exe_req");
    cvt_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cvt_ack) |-> cvt_req)
        else $error("cvt_ack rose without cvt_req");

    // new req waits for the old ack to fall
    exe_req_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(exe_req) |-> !exe_ack)
        else $error("exe_req raised while exe_ack still high");
    cvt_req_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cvt_req) |-> !cvt_ack)
        else $error("cvt_req raised while cvt_ack still high");

endmodule

`default_nettype wire

// ==== logic/cal_top.sv ====
// calculator top level connecting key decode, controller, execute, bcd conversion and display
`timescale 1ns/1ps
`default_nettype none

module cal_top
    import cal_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [BUTTON_W-1:0] board_cal_button,
    input  logic [SWITCH_W-1:0] board_cal_switchs,
    output logic [3:0]          cal_board_digit_ctrl,
    output logic [7:0]          cal_board_digit_seg,
    output logic                cal_board_exe_done,
    output logic [2:0]          cal_board_display_stage
);

    button_t             presses;
    operand_t            entry;
    phase_t              phase;
    operand_t            operand_a;
    operand_t            operand_b;
    logic [SWITCH_W-1:0] op_switches;
    logic                exe_req;
    logic                exe_ack;
    result_t             result;
    logic                cvt_req;
    logic                cvt_ack;
    bcd_result_t         bcd;
    logic                last_page;
    logic                page_step;

    key_decode key_decode_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .buttons (board_cal_button),
        .phase   (phase),
        .presses (presses),
        .entry   (entry)
    );

    cal_ctrl cal_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .presses     (presses),
        .entry       (entry),
        .switches    (board_cal_switchs),
        .exe_ack     (exe_ack),
        .cvt_ack     (cvt_ack),
        .last_page   (last_page),
        .phase       (phase),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .op_switches (op_switches),
        .exe_req     (exe_req),
        .cvt_req     (cvt_req),
        .page_step   (page_step),
        .exe_done    (cal_board_exe_done)
    );

    cal_execute cal_execute_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .exe_req     (exe_req),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .op_switches (op_switches),
        .exe_ack     (exe_ack),
        .result      (result)
    );

    bin2bcd bin2bcd_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cvt_req (cvt_req),
        .result  (result),
        .cvt_ack (cvt_ack),
        .bcd     (bcd)
    );

    seg_display seg_display_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .phase         (phase),
        .entry         (entry),
        .bcd           (bcd),
        .page_step     (page_step),
        .digit_ctrl    (cal_board_digit_ctrl),
        .digit_seg     (cal_board_digit_seg),
        .last_page     (last_page),
        .display_stage (cal_board_display_stage)
    );

endmodule

`default_nettype wire

// ==== logic/seg_display.sv ====
// digit scan enable, digit multiplexing, result paging and seven-segment encoder
`timescale 1ns/1ps
`default_nettype none

module seg_display
    import cal_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  phase_t      phase,
    input  operand_t    entry,
    input  bcd_result_t bcd,
    input  logic        page_step,
    output logic [3:0]  digit_ctrl,
    output logic [7:0]  digit_seg,
    output logic        last_page,
    output logic [2:0]  display_stage
);

    logic [$clog2(SCAN_TICKS)-1:0] tick_cnt;
    logic [1:0]                    pos;
    logic                          page;
    logic                          in_display;
    logic                          two_pages;
    logic                          hi_group;
    logic [DIGIT_W-1:0]            code;

    function automatic logic [DIGIT_W-1:0] sign_code(logic neg);
        return neg ? CODE_MINUS : CODE_BLANK;
    endfunction

    // active-low segments, dp in bit 0
    function automatic logic [7:0] seg_encode(logic [DIGIT_W-1:0] c);
        case (c)
            4'h0:    return 8'b0000_0011;
            4'h1:    return 8'b1001_1111;
            4'h2:    return 8'b0010_0101;
            4'h3:    return 8'b0000_1101;
            4'h4:    return 8'b1001_1001;
            4'h5:    return 8'b0100_1001;
            4'h6:    return 8'b0100_0001;
            4'h7:    return 8'b0001_1111;
            4'h8:    return 8'b0000_0001;
            4'h9:    return 8'b0001_1001;
            4'hb:    return 8'b1111_1101;
            default: return 8'b1111_1111;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            pos      <= '0;
        end else if (tick_cnt == SCAN_TICKS - 1) begin
            tick_cnt <= '0;
            pos      <= pos + 2'd1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign in_display = (phase == ph_display);
    // a magnitude of 1000 or more needs the high group page
    assign two_pages  = !bcd.invalid && (bcd.digits[RES_DIGITS-1:NUM_DIGITS] != '0);
    assign last_page  = !two_pages || page;
    assign hi_group   = two_pages && !page;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            page <= 1'b0;
        end else if (!in_display) begin
            page <= 1'b0;
        end else if (page_step && !last_page) begin
            page <= 1'b1;
        end
    end

    always_comb begin
        case (phase)
            ph_input_a, ph_input_b: begin
                code = (pos == 2'd3) ? sign_code(entry.sign) : entry.digits[pos];
            end
            ph_display: begin
                if (pos == 2'd3) begin
                    code = sign_code(bcd.sign);
                end else if (hi_group) begin
                    code = bcd.digits[{1'b0, pos} + 3'd3];
                end else begin
                    code = bcd.digits[pos];
                end
            end
            default: code = CODE_BLANK;
        endcase
    end

    // invalid result keeps every digit dark
    assign digit_ctrl    = (in_display && bcd.invalid) ? 4'b1111 : ~(4'b0001 << pos);
    assign digit_seg     = seg_encode(code);
    assign display_stage = in_display ? {2'b00, page} + 3'd1 : 3'd0;

endmodule

`default_nettype wire

// ==== logic/bin2bcd.sv ====
// sequential shift-add-3 conversion of the result magnitude to six bcd digits
`timescale 1ns/1ps
`default_nettype none

module bin2bcd
    import cal_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cvt_req,
    input  result_t     result,
    output logic        cvt_ack,
    output bcd_result_t bcd
);

    logic [RESULT_W-1:0]                    magnitude;
    logic [RESULT_W-1:0]                    bin_sh;
    logic [RES_DIGITS*DIGIT_W+RESULT_W-1:0] acc;
    logic [4:0]                             shift_cnt;
    logic                                   busy;
    logic                                   start;

    assign magnitude = result.value[RESULT_W-1] ? -result.value : result.value;
    assign start     = cvt_req && !busy && !cvt_ack;

    // first shift happens on the load cycle
    always_comb begin
        acc = busy ? {bcd.digits, bin_sh} : {{(RES_DIGITS*DIGIT_W){1'b0}}, magnitude};
        for (int i = 0; i < RES_DIGITS; i++) begin
            if (acc[RESULT_W+i*DIGIT_W +: DIGIT_W] > 4'd4) begin
                acc[RESULT_W+i*DIGIT_W +: DIGIT_W] = acc[RESULT_W+i*DIGIT_W +: DIGIT_W] + 4'd3;
            end
        end
        acc = acc << 1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            shift_cnt <= '0;
            cvt_ack   <= 1'b0;
        end else if (start) begin
            busy      <= 1'b1;
            shift_cnt <= 5'd1;
        end else if (busy) begin
            shift_cnt <= shift_cnt + 5'd1;
            if (shift_cnt == 5'(RESULT_W - 1)) begin
                busy    <= 1'b0;
                cvt_ack <= 1'b1;
            end
        end else if (!cvt_req) begin
            cvt_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            bcd.sign    <= result.value[RESULT_W-1];
            bcd.invalid <= result.invalid;
        end
        if (start || busy) begin
            {bcd.digits, bin_sh} <= acc;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cal_execute.sv ====
// operand bcd to binary, operation decode and add/sub/mul execute stage
`timescale 1ns/1ps
`default_nettype none

module cal_execute
    import cal_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                exe_req,
    input  operand_t            operand_a,
    input  operand_t            operand_b,
    input  logic [SWITCH_W-1:0] op_switches,
    output logic                exe_ack,
    output result_t             result
);

    logic signed [RESULT_W-1:0] a_bin;
    logic signed [RESULT_W-1:0] b_bin;
    logic signed [RESULT_W-1:0] value;
    op_t                        op;

    function automatic logic signed [RESULT_W-1:0] to_bin(operand_t opd);
        logic signed [RESULT_W-1:0] mag;
        mag = RESULT_W'(opd.digits[2] * 10'd100 + opd.digits[1] * 10'd10 + opd.digits[0]);
        return opd.sign ? -mag : mag;
    endfunction

    assign a_bin = to_bin(operand_a);
    assign b_bin = to_bin(operand_b);

    // lowest set switch wins
    always_comb begin
        if (op_switches[OP_ADD]) begin
            op = op_add;
        end else if (op_switches[OP_SUB]) begin
            op = op_sub;
        end else if (op_switches[OP_MUL]) begin
            op = op_mul;
        end else begin
            op = op_invalid;
        end
    end

    always_comb begin
        case (op)
            op_add:  value = a_bin + b_bin;
            op_sub:  value = a_bin - b_bin;
            op_mul:  value = a_bin * b_bin;
            default: value = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_ack <= 1'b0;
        end else begin
            exe_ack <= exe_req;
        end
    end

    // result held until the next request
    always_ff @(posedge clk) begin
        if (exe_req && !exe_ack) begin
            result.value   <= value;
            result.invalid <= (op == op_invalid);
        end
    end

endmodule

`default_nettype wire

// ==== logic/cal_ctrl.sv ====
// main phase FSM, operand and switch capture, exe and cvt handshake masters
`timescale 1ns/1ps
`default_nettype none

module cal_ctrl
    import cal_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  button_t             presses,
    input  operand_t            entry,
    input  logic [SWITCH_W-1:0] switches,
    input  logic                exe_ack,
    input  logic                cvt_ack,
    input  logic                last_page,
    output phase_t              phase,
    output operand_t            operand_a,
    output operand_t            operand_b,
    output logic [SWITCH_W-1:0] op_switches,
    output logic                exe_req,
    output logic                cvt_req,
    output logic                page_step,
    output logic                exe_done
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= ph_input_a;
            exe_req <= 1'b0;
            cvt_req <= 1'b0;
        end else begin
            case (phase)
                ph_input_a: begin
                    if (presses.mid) begin
                        phase <= ph_input_b;
                    end
                end
                ph_input_b: begin
                    if (presses.mid) begin
                        phase   <= ph_execute;
                        exe_req <= 1'b1;
                    end
                end
                // drop req on ack, move on once ack has fallen
                ph_execute: begin
                    if (exe_req && exe_ack) begin
                        exe_req <= 1'b0;
                    end else if (!exe_req && !exe_ack) begin
                        phase   <= ph_convert;
                        cvt_req <= 1'b1;
                    end
                end
                ph_convert: begin
                    if (cvt_req && cvt_ack) begin
                        cvt_req <= 1'b0;
                    end else if (!cvt_req && !cvt_ack) begin
                        phase <= ph_display;
                    end
                end
                ph_display: begin
                    if (presses.mid && last_page) begin
                        phase <= ph_input_a;
                    end
                end
                default: phase <= ph_input_a;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == ph_input_a && presses.mid) begin
            operand_a <= entry;
        end
        if (phase == ph_input_b && presses.mid) begin
            operand_b   <= entry;
            op_switches <= switches;
        end
    end

    assign page_step = (phase == ph_display) && presses.mid && !last_page;
    assign exe_done  = (phase == ph_display);

endmodule

`default_nettype wire

// ==== logic/key_decode.sv ====
// button sync and edge detect, press priority, cursor FSM and digit entry registers
`timescale 1ns/1ps
`default_nettype none

module key_decode
    import cal_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [BUTTON_W-1:0] buttons,
    input  phase_t              phase,
    output button_t             presses,
    output operand_t            entry
);

    // low two bits double as the digit index
    typedef enum logic [2:0] {
        cur_digit0 = 3'd0,
        cur_digit1 = 3'd1,
        cur_digit2 = 3'd2,
        cur_sign   = 3'd3,
        cur_idle   = 3'd4
    } cursor_t;

    logic [BUTTON_W-1:0] sync1;
    logic [BUTTON_W-1:0] sync2;
    logic [BUTTON_W-1:0] prev;
    logic [BUTTON_W-1:0] rise;
    logic [BUTTON_W-1:0] first;
    phase_t              phase_q;
    logic                phase_chg;
    logic                in_input;
    logic                adjust;
    cursor_t             cursor;
    logic [1:0]          cur_idx;

    function automatic logic [DIGIT_W-1:0] step_digit(logic [DIGIT_W-1:0] d, logic up);
        if (up) begin
            return (d == 4'd9) ? 4'd0 : d + 4'd1;
        end
        return (d == 4'd0) ? 4'd9 : d - 4'd1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1   <= '0;
            sync2   <= '0;
            prev    <= '0;
            presses <= '0;
        end else begin
            sync1         <= buttons;
            sync2         <= sync1;
            prev          <= sync2;
            presses.left  <= first[BTN_LEFT];
            presses.right <= first[BTN_RIGHT];
            presses.up    <= first[BTN_UP];
            presses.down  <= first[BTN_DOWN];
            presses.mid   <= first[BTN_MID];
        end
    end

    assign rise = sync2 & ~prev;
    // isolate the lowest new press
    assign first = rise & (~rise + BUTTON_W'(1));

    assign in_input  = (phase == ph_input_a) || (phase == ph_input_b);
    assign phase_chg = (phase != phase_q);
    assign adjust    = presses.up || presses.down;
    assign cur_idx   = cursor[1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= ph_input_a;
            cursor  <= cur_digit0;
        end else begin
            phase_q <= phase;
            if (phase_chg) begin
                cursor <= in_input ? cur_digit0 : cur_idle;
            end else if (cursor != cur_idle) begin
                // left walks toward the sign
                if (presses.left && cursor != cur_sign) begin
                    cursor <= cursor_t'(cursor + 3'd1);
                end else if (presses.right && cursor != cur_digit0) begin
                    cursor <= cursor_t'(cursor - 3'd1);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry <= '0;
        end else if (phase_chg) begin
            entry <= '0;
        end else if (adjust && cursor == cur_sign) begin
            entry.sign <= ~entry.sign;
        end else if (adjust && cursor != cur_idle) begin
            entry.digits[cur_idx] <= step_digit(entry.digits[cur_idx], presses.up);
        end
    end

endmodule

`default_nettype wire

// ==== logic/cal_pkg.sv ====
// calculator widths, button and switch indices, display codes, scan timing and shared types
`default_nettype none

package cal_pkg;

    localparam int DIGIT_W    = 4;
    localparam int NUM_DIGITS = 3;

    // lower index has priority
    localparam int BUTTON_W  = 5;
    localparam int BTN_LEFT  = 0;
    localparam int BTN_RIGHT = 1;
    localparam int BTN_UP    = 2;
    localparam int BTN_DOWN  = 3;
    localparam int BTN_MID   = 4;

    localparam int SWITCH_W = 15;
    localparam int OP_ADD   = 0;
    localparam int OP_SUB   = 1;
    localparam int OP_MUL   = 2;

    // signed result covering +-998001
    localparam int RESULT_W   = 21;
    localparam int RES_DIGITS = 6;

    localparam logic [DIGIT_W-1:0] CODE_BLANK = 4'ha;
    localparam logic [DIGIT_W-1:0] CODE_MINUS = 4'hb;

    // clocks per scanned digit position
    localparam int SCAN_TICKS = 4;

    // one-cycle press pulses with left in bit 0
    typedef struct packed {
        logic mid;
        logic down;
        logic up;
        logic right;
        logic left;
    } button_t;

    typedef struct packed {
        logic                               sign;
        logic [NUM_DIGITS-1:0][DIGIT_W-1:0] digits;
    } operand_t;

    typedef enum logic [1:0] {op_add, op_sub, op_mul, op_invalid} op_t;

    typedef struct packed {
        logic                       invalid;
        logic signed [RESULT_W-1:0] value;
    } result_t;

    typedef struct packed {
        logic                               invalid;
        logic                               sign;
        logic [RES_DIGITS-1:0][DIGIT_W-1:0] digits;
    } bcd_result_t;

    typedef enum logic [2:0] {
        ph_input_a,
        ph_input_b,
        ph_execute,
        ph_convert,
        ph_display
    } phase_t;

endpackage

`default_nettype wire
